// ==== rtl/dcachePkg.sv ====
`default_nettype none

package dcachePkg;

  parameter int ADDR_WIDTH = 32;
  parameter int WORD_WIDTH = 32;

  // encoding of the load/store unit's access type field
  typedef enum logic [1:0] {
    accNone = 2'b00,
    accByte = 2'b01,
    accHalf = 2'b10,
    accWord = 2'b11
  } accessSizeT;

  typedef enum logic [2:0] {
    stIdle,
    stLookup,
    stWriteBack,
    stRefill,
    stRespond
  } ctrlStateT;

  // bytes touched by one access
  function automatic int sizeBytes(accessSizeT size);
    int count;
    case (size)
      accByte: count = 1;
      accHalf: count = 2;
      accWord: count = 4;
      default: count = 0;
    endcase
    return count;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/byteLaneBank.sv ====
`default_nettype none

module byteLaneBank #(
  parameter int indexWidth = 5
) (
  input  logic                  clkIn,
  input  logic [indexWidth-1:0] lineIndex,
  input  logic                  readEnable,
  input  logic                  writeEnable,
  input  logic [7:0]            writeByte,
  output logic [7:0]            readByte
);

  localparam int lineCount = 2 ** indexWidth;

  logic [7:0] laneMem [lineCount]; // one byte of every line

  always_ff @(posedge clkIn) begin
    if (writeEnable) begin
      laneMem[lineIndex] <= writeByte;
    end
    // holds its value while not enabled, the writeback relies on that
    if (readEnable) begin
      readByte <= laneMem[lineIndex];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/readPath.sv ====
`default_nettype none

module readPath #(
  parameter int blockWidth = 4
) (
  input  logic                                clkIn,
  input  logic                                resetIn,
  input  logic [(2**blockWidth)*8-1:0]        laneReadData,
  input  logic                                loadStrobe,
  input  logic [blockWidth-1:0]               reqOffset,
  input  dcachePkg::accessSizeT               reqSize,
  output logic                                loadValid,
  output logic [dcachePkg::WORD_WIDTH-1:0]    loadData,
  output logic [(2**blockWidth)*8-1:0]        memLineOut
);
  import dcachePkg::*;

  localparam int lineBits = (2 ** blockWidth) * 8;

  logic [lineBits-1:0]   shiftedLine;
  logic [WORD_WIDTH-1:0] sizeMask;
  logic [WORD_WIDTH-1:0] alignedWord;

  always_comb begin
    shiftedLine = laneReadData >> (8 * reqOffset); // first byte lands in lane 0
    case (reqSize)
      accByte: sizeMask = WORD_WIDTH'(8'hff);
      accHalf: sizeMask = WORD_WIDTH'(16'hffff);
      accWord: sizeMask = '1;
      default: sizeMask = '0;
    endcase
    alignedWord = shiftedLine[WORD_WIDTH-1:0] & sizeMask; // zero extension
  end

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      loadValid <= 1'b0;
    end else begin
      loadValid <= loadStrobe;
    end
  end

  always_ff @(posedge clkIn) begin
    if (loadStrobe) begin
      loadData <= alignedWord;
    end
  end

  // lanes still hold the victim line read during lookup
  assign memLineOut = laneReadData;

endmodule

`default_nettype wire

// ==== rtl/cacheController.sv ====
`default_nettype none

module cacheController #(
  parameter int blockWidth = 4,
  parameter int indexWidth = 5
) (
  input  logic                                           clkIn,
  input  logic                                           resetIn,
  input  logic                                           reqValid,
  input  logic                                           reqWrite,
  input  dcachePkg::accessSizeT                          reqSize,
  input  logic [dcachePkg::ADDR_WIDTH-1:0]               reqAddr,
  input  logic [dcachePkg::WORD_WIDTH-1:0]               reqData,
  output logic                                           reqReady,
  output logic                                           storeDone,
  output logic                                           memReq,
  output logic                                           memWrite,
  output logic [dcachePkg::ADDR_WIDTH-blockWidth-1:0]    memAddr,
  input  logic                                           memAck,
  input  logic [(2**blockWidth)*8-1:0]                   memLineIn,
  output logic [indexWidth-1:0]                          lineIndex,
  output logic                                           readEnable,
  output logic [2**blockWidth-1:0]                       laneWriteEnable,
  output logic [(2**blockWidth)*8-1:0]                   laneWriteData,
  output logic                                           loadStrobe,
  output logic [blockWidth-1:0]                          reqOffset,
  output dcachePkg::accessSizeT                          pendingSize
);
  import dcachePkg::*;

  localparam int lineBytes = 2 ** blockWidth;
  localparam int lineCount = 2 ** indexWidth;
  localparam int tagWidth  = ADDR_WIDTH - blockWidth - indexWidth;

  ctrlStateT state;

  // registered request
  logic [ADDR_WIDTH-1:0] alignedAddr;
  logic [ADDR_WIDTH-1:0] reqAddrReg;
  logic [WORD_WIDTH-1:0] reqDataReg;
  logic                  reqWriteReg;

  logic [indexWidth-1:0] reqIndex;
  logic [tagWidth-1:0]   reqTag;

  // per-line bookkeeping
  logic [lineCount-1:0] validBits;
  logic [lineCount-1:0] dirtyBits;
  logic [tagWidth-1:0]  tagArr [lineCount];

  logic hit;
  logic victimDirty;
  logic storeWrite;
  logic refillWrite;

  logic [lineBytes-1:0]   storeMask;
  logic [lineBytes*8-1:0] storeLine;

  assign reqOffset = reqAddrReg[blockWidth-1:0];
  assign reqIndex  = reqAddrReg[blockWidth +: indexWidth];
  assign reqTag    = reqAddrReg[ADDR_WIDTH-1 -: tagWidth];

  assign hit         = validBits[reqIndex] && (tagArr[reqIndex] == reqTag);
  assign victimDirty = validBits[reqIndex] && dirtyBits[reqIndex];
  assign storeWrite  = (state == stLookup) && hit && reqWriteReg;
  assign refillWrite = (state == stRefill) && memReq && memAck;

  assign reqReady   = (state == stIdle);
  assign readEnable = (state == stLookup); // also fetches the victim line on a miss
  assign lineIndex  = reqIndex;
  assign loadStrobe = (state == stRespond) && !reqWriteReg;

  // low offset bits cleared to the access size
  always_comb begin
    case (reqSize)
      accHalf: alignedAddr = {reqAddr[ADDR_WIDTH-1:1], 1'b0};
      accWord: alignedAddr = {reqAddr[ADDR_WIDTH-1:2], 2'b00};
      default: alignedAddr = reqAddr;
    endcase
  end

  always_ff @(posedge clkIn) begin
    if (reqValid && reqReady) begin
      reqAddrReg  <= alignedAddr;
      reqDataReg  <= reqData;
      reqWriteReg <= reqWrite;
      pendingSize <= reqSize;
    end
    if (refillWrite) begin
      tagArr[reqIndex] <= reqTag;
    end
  end

  // store bytes placed on their lanes, lowest byte at the offset
  always_comb begin
    storeLine = (lineBytes * 8)'(reqDataReg) << (8 * reqOffset);
    storeMask = (lineBytes)'((1 << sizeBytes(pendingSize)) - 1) << reqOffset;
  end

  always_comb begin
    laneWriteEnable = '0;
    laneWriteData   = '0;
    if (refillWrite) begin
      laneWriteEnable = '1; // whole line from memory
      laneWriteData   = memLineIn;
    end else if (storeWrite) begin
      laneWriteEnable = storeMask;
      laneWriteData   = storeLine;
    end
  end

  // memory side, the address follows the state
  assign memWrite = (state == stWriteBack);
  assign memAddr  = memWrite ? {tagArr[reqIndex], reqIndex} : {reqTag, reqIndex};

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      state     <= stIdle;
      validBits <= '0;
      dirtyBits <= '0;
      memReq    <= 1'b0;
      storeDone <= 1'b0;
    end else begin
      storeDone <= storeWrite;
      case (state)
        stIdle: begin
          if (reqValid) begin
            state <= stLookup;
          end
        end
        stLookup: begin
          if (hit) begin
            state <= stRespond;
            if (reqWriteReg) begin
              dirtyBits[reqIndex] <= 1'b1;
            end
          end else begin
            memReq <= 1'b1;
            state  <= victimDirty ? stWriteBack : stRefill;
          end
        end
        stWriteBack: begin
          if (memAck) begin
            memReq <= 1'b0; // one idle cycle before the refill request
            state  <= stRefill;
          end
        end
        stRefill: begin
          if (refillWrite) begin
            memReq              <= 1'b0;
            validBits[reqIndex] <= 1'b1;
            dirtyBits[reqIndex] <= 1'b0;
            state               <= stLookup; // replays as a hit
          end else begin
            memReq <= 1'b1;
          end
        end
        stRespond: begin
          state <= stIdle;
        end
        default: begin
          state <= stIdle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dataCache.sv ====
`default_nettype none

module dataCache #(
  parameter int blockWidth = 4,
  parameter int indexWidth = 5
) (
  input  logic                                           clkIn,
  input  logic                                           resetIn,
  input  logic                                           reqValid,
  input  logic                                           reqWrite,
  input  dcachePkg::accessSizeT                          reqSize,
  input  logic [dcachePkg::ADDR_WIDTH-1:0]               reqAddr,
  input  logic [dcachePkg::WORD_WIDTH-1:0]               reqData,
  output logic                                           reqReady,
  output logic                                           loadValid,
  output logic                                           storeDone,
  output logic [dcachePkg::WORD_WIDTH-1:0]               loadData,
  output logic                                           memReq,
  output logic                                           memWrite,
  output logic [dcachePkg::ADDR_WIDTH-blockWidth-1:0]    memAddr,
  output logic [(2**blockWidth)*8-1:0]                   memLineOut,
  input  logic                                           memAck,
  input  logic [(2**blockWidth)*8-1:0]                   memLineIn
);
  import dcachePkg::*;

  localparam int lineBytes = 2 ** blockWidth;

  logic [indexWidth-1:0]  lineIndex;
  logic                   readEnable;
  logic [lineBytes-1:0]   laneWriteEnable;
  logic [lineBytes*8-1:0] laneWriteData;
  logic [lineBytes*8-1:0] laneReadData;
  logic                   loadStrobe;
  logic [blockWidth-1:0]  reqOffset;
  accessSizeT             pendingSize;

  cacheController #(
    .blockWidth(blockWidth),
    .indexWidth(indexWidth)
  ) i_cacheController (
    .clkIn           (clkIn),
    .resetIn         (resetIn),
    .reqValid        (reqValid),
    .reqWrite        (reqWrite),
    .reqSize         (reqSize),
    .reqAddr         (reqAddr),
    .reqData         (reqData),
    .reqReady        (reqReady),
    .storeDone       (storeDone),
    .memReq          (memReq),
    .memWrite        (memWrite),
    .memAddr         (memAddr),
    .memAck          (memAck),
    .memLineIn       (memLineIn),
    .lineIndex       (lineIndex),
    .readEnable      (readEnable),
    .laneWriteEnable (laneWriteEnable),
    .laneWriteData   (laneWriteData),
    .loadStrobe      (loadStrobe),
    .reqOffset       (reqOffset),
    .pendingSize     (pendingSize)
  );

  // one bank per byte of a line
  for (genvar lane = 0; lane < lineBytes; lane++) begin : laneGen
    byteLaneBank #(
      .indexWidth(indexWidth)
    ) i_byteLaneBank (
      .clkIn       (clkIn),
      .lineIndex   (lineIndex),
      .readEnable  (readEnable),
      .writeEnable (laneWriteEnable[lane]),
      .writeByte   (laneWriteData[8*lane +: 8]),
      .readByte    (laneReadData[8*lane +: 8])
    );
  end

  readPath #(
    .blockWidth(blockWidth)
  ) i_readPath (
    .clkIn        (clkIn),
    .resetIn      (resetIn),
    .laneReadData (laneReadData),
    .loadStrobe   (loadStrobe),
    .reqOffset    (reqOffset),
    .reqSize      (pendingSize),
    .loadValid    (loadValid),
    .loadData     (loadData),
    .memLineOut   (memLineOut)
  );

endmodule

`default_nettype wire

// ==== testbench/dataCache_assert.sv ====
`default_nettype none

module dataCacheAssert #(
  parameter int lineAddrWidth = 28,
  parameter int lineBits      = 128
) (
  input logic                     clkIn,
  input logic                     resetIn,
  input logic                     reqValid,
  input logic                     reqWrite,
  input logic                     reqReady,
  input logic                     loadValid,
  input logic                     storeDone,
  input logic                     memReq,
  input logic                     memWrite,
  input logic                     memAck,
  input logic [lineAddrWidth-1:0] memAddr,
  input logic [lineBits-1:0]      memLineOut
);

  logic loadPending; // load accepted, result not yet out

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      loadPending <= 1'b0;
    end else if (reqValid && reqReady && !reqWrite) begin
      loadPending <= 1'b1;
    end else if (loadValid) begin
      loadPending <= 1'b0;
    end
  end

  // request and its payload held until the acknowledge
  memReqHeld: assert property (@(posedge clkIn) disable iff (resetIn)
    memReq && !memAck |=> memReq && $stable(memAddr) && $stable(memWrite)
      && $stable(memLineOut))
    else $error("memReq dropped or its payload changed before memAck");

  noAckWithoutReq: assert property (@(posedge clkIn) disable iff (resetIn)
    memAck |-> memReq)
    else $error("memAck seen without a memory request");

  busyWhileLoad: assert property (@(posedge clkIn) disable iff (resetIn)
    loadPending && !loadValid |-> !reqReady)
    else $error("reqReady high while a load result is pending");

  oneDone: assert property (@(posedge clkIn) disable iff (resetIn)
    !(loadValid && storeDone))
    else $error("loadValid and storeDone high in the same cycle");

endmodule

bind dataCache dataCacheAssert #(
  .lineAddrWidth(dcachePkg::ADDR_WIDTH - blockWidth),
  .lineBits((2 ** blockWidth) * 8)
) i_dataCacheAssert (
  .clkIn      (clkIn),
  .resetIn    (resetIn),
  .reqValid   (reqValid),
  .reqWrite   (reqWrite),
  .reqReady   (reqReady),
  .loadValid  (loadValid),
  .storeDone  (storeDone),
  .memReq     (memReq),
  .memWrite   (memWrite),
  .memAck     (memAck),
  .memAddr    (memAddr),
  .memLineOut (memLineOut)
);

`default_nettype wire

// ==== testbench/dataCacheTb.sv ====
`default_nettype none

module dataCacheTb;
  import dcachePkg::*;

  localparam int clockPeriod = 10;
  localparam int blockBits   = 4;
  localparam int indexBits   = 5;
  localparam int lineBytes   = 2 ** blockBits;
  localparam int rowBound    = 40; // cycles per row, a dirty miss needs about 20
  localparam int randomRows  = 24;
  localparam logic [ADDR_WIDTH-1:0] addrA      = 32'h0000_1230; // index 3
  localparam logic [ADDR_WIDTH-1:0] addrB      = 32'h0000_1430; // index 3, next tag
  localparam logic [ADDR_WIDTH-1:0] addrC      = 32'h0000_2450;
  localparam logic [ADDR_WIDTH-1:0] randomBase = 32'h0004_0000;

  typedef struct packed {
    int                    group;
    logic                  write;
    accessSizeT            size;
    logic [ADDR_WIDTH-1:0] addr;
    logic [WORD_WIDTH-1:0] data;
    logic                  expectMiss;
    int                    hitCycles; // exact latency, 0 when memory decides it
    logic                  checkLine; // memory line at lineAddr must match the reference
    logic [ADDR_WIDTH-1:0] lineAddr;
  } stimRowT;

  logic clkIn = 1'b0;
  logic resetIn;
  logic reqValid;
  logic reqWrite;
  accessSizeT reqSize;
  logic [ADDR_WIDTH-1:0] reqAddr;
  logic [WORD_WIDTH-1:0] reqData;
  logic reqReady;
  logic loadValid;
  logic storeDone;
  logic [WORD_WIDTH-1:0] loadData;
  logic memReq;
  logic memWrite;
  logic [ADDR_WIDTH-blockBits-1:0] memAddr;
  logic [lineBytes*8-1:0] memLineOut;
  logic memAck;
  logic [lineBytes*8-1:0] memLineIn;

  logic [7:0] modelMem [int unsigned]; // written bytes only
  logic [7:0] refMem [int unsigned];
  stimRowT stimTable [$];
  logic [31:0] lfsrState = 32'd84841;
  logic tableReady = 1'b0;
  int checkCount = 0;
  int errorCount = 0;

  dataCache i_dataCache (.*);

  always #(clockPeriod / 2) clkIn = ~clkIn;

  // taps 32 22 2 1
  function automatic logic [31:0] nextLfsr(logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  function automatic logic [31:0] drawBits(int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = nextLfsr(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  function automatic logic [7:0] initByte(logic [ADDR_WIDTH-1:0] addr);
    return 8'h5a ^ addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24];
  endfunction

  function automatic logic [7:0] modelByte(logic [ADDR_WIDTH-1:0] addr);
    if (modelMem.exists(addr)) begin
      return modelMem[addr];
    end
    return initByte(addr);
  endfunction

  function automatic logic [7:0] refByte(logic [ADDR_WIDTH-1:0] addr);
    if (refMem.exists(addr)) begin
      return refMem[addr];
    end
    return initByte(addr);
  endfunction

  function automatic int accessBytes(accessSizeT size);
    case (size)
      accByte: return 1;
      accHalf: return 2;
      accWord: return 4;
      default: return 0;
    endcase
  endfunction

  // half-words on even, words on multiples of four
  function automatic logic [ADDR_WIDTH-1:0] alignAddr(logic [ADDR_WIDTH-1:0] addr,
                                                       accessSizeT size);
    return addr & ~(accessBytes(size) - 1);
  endfunction

  function automatic logic [WORD_WIDTH-1:0] refLoad(logic [ADDR_WIDTH-1:0] addr,
                                                     accessSizeT size);
    logic [WORD_WIDTH-1:0] value;
    value = '0; // upper bytes stay zero
    for (int i = 0; i < accessBytes(size); i++) begin
      value[8*i +: 8] = refByte(addr + i);
    end
    return value;
  endfunction

  task automatic addRow(input int group, input logic write, input accessSizeT size,
                        input logic [ADDR_WIDTH-1:0] addr, input logic [WORD_WIDTH-1:0] data,
                        input logic expectMiss, input int hitCycles);
    stimRowT row;
    row.group      = group;
    row.write      = write;
    row.size       = size;
    row.addr       = addr;
    row.data       = data;
    row.expectMiss = expectMiss;
    row.hitCycles  = hitCycles;
    row.checkLine  = 1'b0;
    row.lineAddr   = '0;
    stimTable.push_back(row);
  endtask

  task automatic addLineCheck(input logic [ADDR_WIDTH-1:0] lineAddr);
    stimRowT row;
    row = stimTable.pop_back();
    row.checkLine = 1'b1;
    row.lineAddr  = lineAddr;
    stimTable.push_back(row);
  endtask

  task automatic buildTable();
    logic [31:0] write;
    logic [31:0] sizeCode;
    logic [31:0] tagSel;
    logic [31:0] indexSel;
    logic [31:0] offset;
    logic [31:0] data;
    accessSizeT size;
    addRow(2, 1'b0, accWord, addrA, '0, 1'b1, 0);
    addRow(2, 1'b0, accHalf, addrC + 6, '0, 1'b1, 0);
    addRow(3, 1'b0, accWord, addrA + 4, '0, 1'b0, 3);
    addRow(3, 1'b0, accWord, addrA, '0, 1'b0, 3);
    addRow(3, 1'b0, accByte, addrA + 11, '0, 1'b0, 3);
    addRow(3, 1'b0, accHalf, addrC + 2, '0, 1'b0, 3);
    addRow(4, 1'b1, accByte, addrA + 1, 32'h0000_00a5, 1'b0, 2);
    addRow(4, 1'b1, accHalf, addrA + 6, 32'h0000_beef, 1'b0, 2);
    addRow(4, 1'b1, accWord, addrA + 12, 32'h1234_5678, 1'b0, 2);
    addRow(4, 1'b1, accByte, addrA + 13, 32'h0000_0077, 1'b0, 2);
    addRow(4, 1'b1, accHalf, addrA + 9, 32'hffff_c0de, 1'b0, 2); // lands on offset 8
    addRow(4, 1'b0, accByte, addrA + 1, '0, 1'b0, 3);
    addRow(4, 1'b0, accHalf, addrA, '0, 1'b0, 3);
    addRow(4, 1'b0, accHalf, addrA + 7, '0, 1'b0, 3);
    addRow(4, 1'b0, accWord, addrA + 4, '0, 1'b0, 3);
    addRow(4, 1'b0, accWord, addrA + 8, '0, 1'b0, 3);
    addRow(4, 1'b0, accWord, addrA + 12, '0, 1'b0, 3);
    addRow(4, 1'b0, accByte, addrA + 13, '0, 1'b0, 3);
    addRow(4, 1'b0, accWord, addrA, '0, 1'b0, 3);
    addRow(5, 1'b0, accWord, addrB, '0, 1'b1, 0);
    addLineCheck(addrA);
    addRow(5, 1'b0, accWord, addrA + 12, '0, 1'b1, 0);
    addRow(5, 1'b1, accByte, addrB + 5, 32'h0000_003c, 1'b1, 0);
    addRow(5, 1'b0, accWord, addrB + 4, '0, 1'b0, 3);
    addRow(5, 1'b0, accByte, addrA + 1, '0, 1'b1, 0);
    addLineCheck(addrB);
    addRow(5, 1'b0, accWord, addrA + 8, '0, 1'b0, 3);
    // two indexes, four tags each
    for (int i = 0; i < randomRows; i++) begin
      write    = drawBits(1);
      sizeCode = drawBits(2);
      tagSel   = drawBits(2);
      indexSel = drawBits(1);
      offset   = drawBits(blockBits);
      data     = drawBits(32);
      size = (sizeCode == 0) ? accByte : ((sizeCode == 1) ? accHalf : accWord);
      addRow(6, write[0], size, randomBase + (tagSel << (blockBits + indexBits))
             + ((indexSel + 6) << blockBits) + offset, data, 1'b0, 0);
    end
  endtask

  task automatic applyRow(input stimRowT row);
    int cycles;
    int lineMismatches;
    logic sawMiss;
    logic finished;
    logic [ADDR_WIDTH-1:0] aligned;
    logic [WORD_WIDTH-1:0] expected;
    while (!reqReady) begin
      @(negedge clkIn);
    end
    reqValid = 1'b1;
    reqWrite = row.write;
    reqSize  = row.size;
    reqAddr  = row.addr;
    reqData  = row.data;
    @(negedge clkIn); // accepting edge is behind us
    reqValid = 1'b0;
    cycles   = 1;
    sawMiss  = memReq;
    finished = row.write ? storeDone : loadValid;
    while (!finished) begin
      @(negedge clkIn);
      cycles++;
      sawMiss  = sawMiss | memReq;
      finished = row.write ? storeDone : loadValid;
    end
    aligned = alignAddr(row.addr, row.size);
    if (row.write) begin
      for (int i = 0; i < accessBytes(row.size); i++) begin
        refMem[aligned + i] = row.data[8*i +: 8];
      end
    end else begin
      expected = refLoad(aligned, row.size);
      checkCount++;
      if (loadData !== expected) begin
        errorCount++;
        $display("** Error at time %0t: %0d-byte load at 0x%08h gave 0x%08h, expected 0x%08h",
                 $time, accessBytes(row.size), row.addr, loadData, expected);
      end
    end
    if (row.hitCycles != 0) begin
      checkCount++;
      if (cycles != row.hitCycles) begin
        errorCount++;
        $display("** Error at time %0t: access at 0x%08h took %0d cycles, expected %0d",
                 $time, row.addr, cycles, row.hitCycles);
      end
    end
    if (row.expectMiss) begin
      checkCount++;
      if (!sawMiss) begin
        errorCount++;
        $display("access at 0x%08h should have missed but never requested memory", row.addr);
      end
    end
    if (row.checkLine) begin
      checkCount++;
      lineMismatches = 0;
      for (int i = 0; i < lineBytes; i++) begin
        if (modelByte(row.lineAddr + i) !== refByte(row.lineAddr + i)) begin
          lineMismatches++;
        end
      end
      if (lineMismatches != 0) begin
        errorCount++;
        $display("** Error at time %0t: memory line 0x%08h differs in %0d bytes after writeback",
                 $time, row.lineAddr, lineMismatches);
      end
    end
  endtask

  function automatic string groupName(int group);
    case (group)
      1: return "after reset";
      2: return "cold load";
      3: return "load hits";
      4: return "stores and sizes";
      5: return "eviction";
      default: return "random run";
    endcase
  endfunction

  task automatic reportGroup(input int group, input int checks, input int errors);
    $display("test %0d %s: %0d checks, %0d errors", group, groupName(group), checks, errors);
  endtask

  task automatic runTable();
    int current;
    int startChecks;
    int startErrors;
    current     = stimTable[0].group;
    startChecks = checkCount;
    startErrors = errorCount;
    foreach (stimTable[i]) begin
      if (stimTable[i].group != current) begin
        reportGroup(current, checkCount - startChecks, errorCount - startErrors);
        current     = stimTable[i].group;
        startChecks = checkCount;
        startErrors = errorCount;
      end
      applyRow(stimTable[i]);
    end
    reportGroup(current, checkCount - startChecks, errorCount - startErrors);
  endtask

  // acknowledges 1 to 4 cycles after the request rises
  initial begin : memoryModel
    int delay;
    logic [ADDR_WIDTH-1:0] base;
    memAck    = 1'b0;
    memLineIn = '0;
    forever begin
      @(negedge clkIn);
      memAck = 1'b0;
      if (memReq === 1'b1 && resetIn === 1'b0) begin
        delay = 1 + int'(drawBits(2));
        repeat (delay - 1) @(negedge clkIn);
        base = {memAddr, {blockBits{1'b0}}};
        for (int i = 0; i < lineBytes; i++) begin
          if (memWrite) begin
            modelMem[base + i] = memLineOut[8*i +: 8];
          end else begin
            memLineIn[8*i +: 8] = modelByte(base + i);
          end
        end
        memAck = 1'b1;
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (tableReady);
    limit = stimTable.size() * rowBound + 20;
    repeat (limit) @(posedge clkIn);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : stimulus
    resetIn  = 1'b1;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqSize  = accNone;
    reqAddr  = '0;
    reqData  = '0;
    buildTable();
    tableReady = 1'b1;
    repeat (3) @(negedge clkIn);
    resetIn = 1'b0;
    @(negedge clkIn);
    checkCount++;
    if (reqReady !== 1'b1 || loadValid !== 1'b0 || storeDone !== 1'b0 || memReq !== 1'b0) begin
      errorCount++;
      $display("** Error at time %0t: after reset reqReady=%b loadValid=%b storeDone=%b memReq=%b",
               $time, reqReady, loadValid, storeDone, memReq);
    end
    reportGroup(1, checkCount, errorCount);
    runTable();
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dataCache.f ====
rtl/dcachePkg.sv
rtl/byteLaneBank.sv
rtl/readPath.sv
rtl/cacheController.sv
rtl/dataCache.sv
testbench/dataCache_assert.sv
testbench/dataCacheTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module dataCacheTb \
  -f dataCache.f -o dataCacheSim \
  && ./obj_dir/dataCacheSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
